/* hdl/sys_pkg.sv */
package sys_pkg;

	// datapath and csr address widths
	localparam int xlen = 32;
	localparam int csr_addr_width = 12;

	// machine csr addresses served by the unit
	localparam logic [csr_addr_width-1:0] addr_mstatus = 12'h300;
	localparam logic [csr_addr_width-1:0] addr_mtvec = 12'h305;
	localparam logic [csr_addr_width-1:0] addr_mepc = 12'h341;
	localparam logic [csr_addr_width-1:0] addr_mcause = 12'h342;
	localparam logic [csr_addr_width-1:0] addr_mvendorid = 12'hf11;
	localparam logic [csr_addr_width-1:0] addr_marchid = 12'hf12;

	// mstatus.mpp, both bits
	localparam logic [xlen-1:0] mstatus_mpp_mask = 32'h0000_1800;
	// environment call from m-mode
	localparam logic [xlen-1:0] cause_ecall_m = 32'd11;

	// encoding follows funct3[1:0] of the zicsr forms
	typedef enum logic [1:0] {
		op_none = 2'b00,
		op_write = 2'b01,
		op_set = 2'b10,
		op_clear = 2'b11
	} csr_op_t;

	typedef struct packed {
		logic valid;
		csr_op_t csr_op;
		logic [csr_addr_width-1:0] csr_addr;
		// rs1 value or zero-extended uimm
		logic [xlen-1:0] operand;
		logic [4:0] rd;
		logic ecall;
		logic mret;
		logic [xlen-1:0] pc;
	} sys_cmd_t;

	typedef struct packed {
		logic valid;
		logic [4:0] rd;
		logic [xlen-1:0] data;
	} wb_t;

	typedef struct packed {
		logic valid;
		logic [xlen-1:0] target;
	} redirect_t;

endpackage

/* hdl/sys_decoder.sv */
`timescale 1ns/1ps

module sys_decoder (
	input logic inst_valid,
	input logic [31:0] inst,
	input logic [sys_pkg::xlen-1:0] rs1_data,
	input logic [sys_pkg::xlen-1:0] pc,
	output sys_pkg::sys_cmd_t cmd
);
	import sys_pkg::*;

	// major opcode of the SYSTEM group
	localparam logic [6:0] opcode_system = 7'b1110011;
	// exact encodings, funct3 zero
	localparam logic [31:0] inst_ecall = 32'h0000_0073;
	localparam logic [31:0] inst_mret = 32'h3020_0073;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [4:0] rs1_field;
	logic is_system;
	logic is_csr;
	logic is_ecall;
	logic is_mret;
	logic [xlen-1:0] operand;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	// rs1 index, doubles as uimm for the i-forms
	assign rs1_field = inst[19:15];

	assign is_system = inst_valid && (opcode == opcode_system);

	// funct3[1:0] zero is ecall/mret/ebreak/wfi or reserved 100
	assign is_csr = is_system && (funct3[1:0] != 2'b00);
	assign is_ecall = is_system && (inst == inst_ecall);
	assign is_mret = is_system && (inst == inst_mret);

	// funct3[2] picks the immediate form
	assign operand = funct3[2] ? {{(xlen - 5){1'b0}}, rs1_field} : rs1_data;

	always_comb begin
		cmd = '0;
		cmd.pc = pc;
		if (is_ecall) begin
			// trap request only, no csr access
			cmd.valid = 1'b1;
			cmd.ecall = 1'b1;
		end else if (is_mret) begin
			cmd.valid = 1'b1;
			cmd.mret = 1'b1;
		end else if (is_csr) begin
			cmd.valid = 1'b1;
			cmd.csr_op = csr_op_t'(funct3[1:0]);
			cmd.csr_addr = inst[31:20];
			cmd.operand = operand;
			cmd.rd = inst[11:7];
		end else begin
			// ebreak, wfi and the rest stay invisible
			cmd.valid = 1'b0;
			cmd.csr_op = op_none;
		end
	end

endmodule

/* hdl/csr_file.sv */
`timescale 1ns/1ps

module csr_file #(
	parameter logic [sys_pkg::xlen-1:0] mvendorid = 32'h7973_7978,
	parameter logic [sys_pkg::xlen-1:0] marchid = 32'h015f_de6d
) (
	input logic clock,
	input logic reset,
	input sys_pkg::sys_cmd_t cmd,
	output logic [sys_pkg::xlen-1:0] rd_data,
	output logic [sys_pkg::xlen-1:0] trap_vector,
	output logic [sys_pkg::xlen-1:0] return_pc
);
	import sys_pkg::*;

	// local slot numbers, zero means no csr
	localparam logic [2:0] slot_none = 3'd0;
	localparam logic [2:0] slot_mstatus = 3'd1;
	localparam logic [2:0] slot_mtvec = 3'd2;
	localparam logic [2:0] slot_mepc = 3'd3;
	localparam logic [2:0] slot_mcause = 3'd4;
	localparam logic [2:0] slot_mvendorid = 3'd5;
	localparam logic [2:0] slot_marchid = 3'd6;

	logic [xlen-1:0] mstatus;
	logic [xlen-1:0] mtvec;
	logic [xlen-1:0] mepc;
	logic [xlen-1:0] mcause;

	logic [2:0] slot;
	logic csr_wr;
	logic [xlen-1:0] new_value;

	// write, set or clear applied to the old value
	function automatic logic [xlen-1:0] csr_update(
		input logic [xlen-1:0] old_value,
		input logic [xlen-1:0] operand,
		input csr_op_t op
	);
		logic [xlen-1:0] result;
		case (op)
			op_write: result = operand;
			op_set: result = old_value | operand;
			op_clear: result = old_value & ~operand;
			default: result = old_value;
		endcase
		return result;
	endfunction

	// first step, address to slot
	always_comb begin
		case (cmd.csr_addr)
			addr_mstatus: slot = slot_mstatus;
			addr_mtvec: slot = slot_mtvec;
			addr_mepc: slot = slot_mepc;
			addr_mcause: slot = slot_mcause;
			addr_mvendorid: slot = slot_mvendorid;
			addr_marchid: slot = slot_marchid;
			default: slot = slot_none;
		endcase
	end

	// second step, slot to old value
	always_comb begin
		case (slot)
			slot_mstatus: rd_data = mstatus;
			slot_mtvec: rd_data = mtvec;
			slot_mepc: rd_data = mepc;
			slot_mcause: rd_data = mcause;
			slot_mvendorid: rd_data = mvendorid;
			slot_marchid: rd_data = marchid;
			// unknown addresses read zero
			default: rd_data = '0;
		endcase
	end

	// pre-update values for the redirect
	assign trap_vector = mtvec;
	assign return_pc = mepc;

	// csr access only when no trap or return in this command
	assign csr_wr = cmd.valid && !cmd.ecall && !cmd.mret && (cmd.csr_op != op_none);
	assign new_value = csr_update(rd_data, cmd.operand, cmd.csr_op);

	// mstatus, mpp set on ecall and cleared on mret
	always_ff @(posedge clock) begin
		if (reset) begin
			mstatus <= '0;
		end else if (cmd.valid && cmd.ecall) begin
			mstatus <= mstatus | mstatus_mpp_mask;
		end else if (cmd.valid && cmd.mret) begin
			mstatus <= mstatus & ~mstatus_mpp_mask;
		end else if (csr_wr && (slot == slot_mstatus)) begin
			mstatus <= new_value;
		end
	end

	// mtvec, software written only
	always_ff @(posedge clock) begin
		if (reset) begin
			mtvec <= '0;
		end else if (csr_wr && (slot == slot_mtvec)) begin
			mtvec <= new_value;
		end
	end

	// mepc takes the pc of the ecall
	always_ff @(posedge clock) begin
		if (reset) begin
			mepc <= '0;
		end else if (cmd.valid && cmd.ecall) begin
			mepc <= cmd.pc;
		end else if (csr_wr && (slot == slot_mepc)) begin
			mepc <= new_value;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			mcause <= '0;
		end else if (cmd.valid && cmd.ecall) begin
			mcause <= cause_ecall_m;
		end else if (csr_wr && (slot == slot_mcause)) begin
			mcause <= new_value;
		end
	end

	// mvendorid and marchid have no storage, writes drop out here

endmodule

/* hdl/sys_retire.sv */
`timescale 1ns/1ps

module sys_retire (
	input logic clock,
	input logic reset,
	input sys_pkg::sys_cmd_t cmd,
	input logic [sys_pkg::xlen-1:0] rd_data,
	input logic [sys_pkg::xlen-1:0] trap_vector,
	input logic [sys_pkg::xlen-1:0] return_pc,
	output sys_pkg::wb_t wb,
	output sys_pkg::redirect_t redirect
);
	import sys_pkg::*;

	logic wb_hit;
	logic redirect_hit;
	logic [xlen-1:0] target;

	// writeback only for csr forms with a real destination
	assign wb_hit = cmd.valid && !cmd.ecall && !cmd.mret
		&& (cmd.csr_op != op_none) && (cmd.rd != 5'd0);

	assign redirect_hit = cmd.valid && (cmd.ecall || cmd.mret);

	// ecall wins over mret
	assign target = cmd.ecall ? trap_vector : return_pc;

	always_ff @(posedge clock) begin
		// valid bits are one-cycle pulses
		if (reset) begin
			wb.valid <= 1'b0;
			redirect.valid <= 1'b0;
		end else begin
			wb.valid <= wb_hit;
			redirect.valid <= redirect_hit;
		end

		// payload held until the next matching command
		if (wb_hit) begin
			wb.rd <= cmd.rd;
			wb.data <= rd_data;
		end
		if (redirect_hit) begin
			redirect.target <= target;
		end
	end

endmodule

/* hdl/sys_unit.sv */
`timescale 1ns/1ps

module sys_unit #(
	parameter logic [sys_pkg::xlen-1:0] mvendorid = 32'h7973_7978,
	parameter logic [sys_pkg::xlen-1:0] marchid = 32'h015f_de6d
) (
	input logic clock,
	input logic reset,
	input logic inst_valid,
	input logic [31:0] inst,
	input logic [sys_pkg::xlen-1:0] rs1_data,
	input logic [sys_pkg::xlen-1:0] pc,
	output sys_pkg::wb_t wb,
	output sys_pkg::redirect_t redirect
);
	import sys_pkg::*;

	// decoded command, valid in the strobe cycle
	sys_cmd_t cmd;

	// old csr value and trap targets, all pre-update
	logic [xlen-1:0] rd_data;
	logic [xlen-1:0] trap_vector;
	logic [xlen-1:0] return_pc;

	sys_decoder u_decoder (
		.inst_valid(inst_valid),
		.inst(inst),
		.rs1_data(rs1_data),
		.pc(pc),
		.cmd(cmd)
	);

	// state updates on the edge ending the strobe cycle
	csr_file #(
		.mvendorid(mvendorid),
		.marchid(marchid)
	) u_csr_file (
		.clock(clock),
		.reset(reset),
		.cmd(cmd),
		.rd_data(rd_data),
		.trap_vector(trap_vector),
		.return_pc(return_pc)
	);

	// results one cycle after the strobe
	sys_retire u_retire (
		.clock(clock),
		.reset(reset),
		.cmd(cmd),
		.rd_data(rd_data),
		.trap_vector(trap_vector),
		.return_pc(return_pc),
		.wb(wb),
		.redirect(redirect)
	);

endmodule

/* verification/sys_model.svh */
`ifndef sys_model_svh
`define sys_model_svh

// reference copies of the writable machine csrs
logic [31:0] model_mstatus;
logic [31:0] model_mtvec;
logic [31:0] model_mepc;
logic [31:0] model_mcause;

task automatic model_reset();
	model_mstatus = '0;
	model_mtvec = '0;
	model_mepc = '0;
	model_mcause = '0;
endtask

// read side, constants straight from the spec values
function automatic logic [31:0] model_read(input logic [11:0] addr);
	case (addr)
		addr_mstatus: return model_mstatus;
		addr_mtvec: return model_mtvec;
		addr_mepc: return model_mepc;
		addr_mcause: return model_mcause;
		addr_mvendorid: return 32'h7973_7978;
		addr_marchid: return 32'h015f_de6d;
		default: return 32'h0;
	endcase
endfunction

// read-only and unknown addresses drop the write
task automatic model_write(input logic [11:0] addr, input logic [31:0] value);
	case (addr)
		addr_mstatus: model_mstatus = value;
		addr_mtvec: model_mtvec = value;
		addr_mepc: model_mepc = value;
		addr_mcause: model_mcause = value;
		default: ;
	endcase
endtask

// expected results for one strobe, then the state update
task automatic model_step(input logic valid, input logic [31:0] instruction,
		input logic [31:0] rs1_value, input logic [31:0] pc_value,
		output wb_t exp_wb, output redirect_t exp_redirect);
	logic [2:0] funct3;
	logic [31:0] operand;
	logic [31:0] old_value;
	logic [31:0] new_value;
	exp_wb = '0;
	exp_redirect = '0;
	funct3 = instruction[14:12];
	// uimm forms take the rs1 field itself
	operand = funct3[2] ? {27'b0, instruction[19:15]} : rs1_value;
	if (!valid || instruction[6:0] != 7'b1110011) begin
		// nothing happens
	end else if (instruction == 32'h0000_0073) begin
		// ecall, target is mtvec before the trap
		exp_redirect.valid = 1'b1;
		exp_redirect.target = model_mtvec;
		model_mepc = pc_value;
		model_mcause = 32'd11;
		model_mstatus = model_mstatus | 32'h0000_1800;
	end else if (instruction == 32'h3020_0073) begin
		exp_redirect.valid = 1'b1;
		exp_redirect.target = model_mepc;
		model_mstatus = model_mstatus & ~32'h0000_1800;
	end else if (funct3[1:0] != 2'b00) begin
		old_value = model_read(instruction[31:20]);
		exp_wb.valid = (instruction[11:7] != 5'd0);
		exp_wb.rd = instruction[11:7];
		exp_wb.data = old_value;
		case (funct3[1:0])
			2'b01: new_value = operand;
			2'b10: new_value = old_value | operand;
			default: new_value = old_value & ~operand;
		endcase
		model_write(instruction[31:20], new_value);
	end
endtask

`endif

/* verification/sys_unit_tb.sv */
`timescale 1ns/1ps

module sys_unit_tb;
	import sys_pkg::*;

	localparam int reset_cycles = 10;
	localparam int n_directed = 10;
	localparam int n_random = 400;
	// twice the expected run length
	localparam int timeout_limit = 2 * (n_directed + n_random + reset_cycles);

	logic clock;
	logic reset;
	logic inst_valid;
	logic [31:0] inst;
	logic [31:0] rs1_data;
	logic [31:0] pc;
	wb_t wb;
	redirect_t redirect;

	int wb_errors = 0;
	int redirect_errors = 0;
	int other_errors = 0;
	int cycle_count = 0;
	logic [31:0] rng_state = 32'h5dc9ca00;

	// expectations for the next cycle's outputs
	wb_t wb_queue[$];
	redirect_t redirect_queue[$];

	`include "sys_model.svh"

	sys_unit dut (
		.clock(clock),
		.reset(reset),
		.inst_valid(inst_valid),
		.inst(inst),
		.rs1_data(rs1_data),
		.pc(pc),
		.wb(wb),
		.redirect(redirect)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// hang guard
	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_limit) begin
			$display("run did not finish within %0d cycles, stopping", timeout_limit);
			$display("Test failed");
			$finish;
		end
	end

	function automatic logic [31:0] next_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic logic [31:0] csr_inst(input logic [2:0] funct3, input logic [11:0] addr,
			input logic [4:0] rd, input logic [4:0] rs1_field);
		return {addr, rs1_field, funct3, rd, 7'b1110011};
	endfunction

	// six known addresses, two unused ones
	function automatic logic [11:0] pick_address(input logic [2:0] idx);
		case (idx)
			3'd0: return addr_mstatus;
			3'd1: return addr_mtvec;
			3'd2: return addr_mepc;
			3'd3: return addr_mcause;
			3'd4: return addr_mvendorid;
			3'd5: return addr_marchid;
			3'd6: return 12'h340;
			default: return 12'h7c0;
		endcase
	endfunction

	// payload only matters while valid
	task automatic compare_wb(input wb_t expected, input wb_t actual);
		if (actual.valid !== expected.valid || (expected.valid
				&& (actual.rd !== expected.rd || actual.data !== expected.data))) begin
			wb_errors++;
			$display("Error at %0t: wb expected valid=%b rd=%0d data=%h, actual valid=%b rd=%0d data=%h",
				$time, expected.valid, expected.rd, expected.data,
				actual.valid, actual.rd, actual.data);
		end
	endtask

	task automatic compare_redirect(input redirect_t expected, input redirect_t actual);
		if (actual.valid !== expected.valid
				|| (expected.valid && actual.target !== expected.target)) begin
			redirect_errors++;
			$display("Error at %0t: redirect expected valid=%b target=%h, actual valid=%b target=%h",
				$time, expected.valid, expected.target, actual.valid, actual.target);
		end
	endtask

	task automatic check_pending();
		if (wb_queue.size() == 0 || redirect_queue.size() == 0) begin
			other_errors++;
			$display("no expected result was queued for the cycle at %0t", $time);
		end else begin
			compare_wb(wb_queue.pop_front(), wb);
			compare_redirect(redirect_queue.pop_front(), redirect);
		end
	endtask

	// one strobe per falling edge, checks the previous one first
	task automatic apply(input logic valid, input logic [31:0] instruction,
			input logic [31:0] rs1_value, input logic [31:0] pc_value);
		wb_t exp_wb;
		redirect_t exp_redirect;
		@(negedge clock);
		check_pending();
		inst_valid = valid;
		inst = instruction;
		rs1_data = rs1_value;
		pc = pc_value;
		model_step(valid, instruction, rs1_value, pc_value, exp_wb, exp_redirect);
		wb_queue.push_back(exp_wb);
		redirect_queue.push_back(exp_redirect);
	endtask

	initial begin
		logic [31:0] r;
		logic [3:0] kind;
		logic [2:0] funct3;
		reset = 1'b1;
		inst_valid = 1'b0;
		inst = '0;
		rs1_data = '0;
		pc = '0;
		model_reset();
		repeat (reset_cycles) @(negedge clock);
		reset = 1'b0;
		// nothing valid before the first strobe
		wb_queue.push_back('0);
		redirect_queue.push_back('0);

		// writable csrs come up zero
		for (int i = 0; i < 4; i++) begin
			apply(1'b1, csr_inst(3'b010, pick_address(i[2:0]), 5'd1 + i[4:0], 5'd0),
				32'h0, 32'h100);
		end
		// read-only and unknown addresses ignore writes
		apply(1'b1, csr_inst(3'b001, addr_mvendorid, 5'd0, 5'd3), 32'hffff_ffff, 32'h104);
		apply(1'b1, csr_inst(3'b001, addr_marchid, 5'd0, 5'd3), 32'hffff_ffff, 32'h108);
		apply(1'b1, csr_inst(3'b101, 12'h340, 5'd5, 5'd31), 32'h0, 32'h10c);
		apply(1'b1, csr_inst(3'b010, addr_mvendorid, 5'd6, 5'd0), 32'h0, 32'h110);
		apply(1'b1, csr_inst(3'b010, addr_marchid, 5'd7, 5'd0), 32'h0, 32'h114);
		apply(1'b1, csr_inst(3'b010, 12'h340, 5'd8, 5'd0), 32'h0, 32'h118);

		// random mix, back to back
		for (int i = 0; i < n_random; i++) begin
			r = next_random();
			kind = r[31:28];
			// op field never zero for a csr form
			funct3 = {r[27], (r[26:25] == 2'b00) ? 2'b01 : r[26:25]};
			r = next_random();
			if (kind < 4'd11) begin
				apply(1'b1, csr_inst(funct3, pick_address(r[31:29]), r[28:24], r[23:19]),
					next_random(), next_random() & 32'hffff_fffc);
			end else if (kind < 4'd13) begin
				apply(1'b1, 32'h0000_0073, next_random(), {r[29:0], 2'b00});
			end else if (kind == 4'd13) begin
				apply(1'b1, 32'h3020_0073, next_random(), {r[29:0], 2'b00});
			end else begin
				apply(1'b0, next_random(), next_random(), {r[29:0], 2'b00});
			end
		end

		// flush the last result
		apply(1'b0, 32'h0, 32'h0, 32'h0);
		@(negedge clock);
		check_pending();

		$display("wb errors: %0d, redirect errors: %0d, other errors: %0d",
			wb_errors, redirect_errors, other_errors);
		if (wb_errors == 0 && redirect_errors == 0 && other_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* sim.f */
+incdir+verification
hdl/sys_pkg.sv
hdl/sys_decoder.sv
hdl/csr_file.sv
hdl/sys_retire.sv
hdl/sys_unit.sv
verification/sys_unit_tb.sv
